//--- verilog/flight_pkg.sv
/* Flight control shared types */

package flight_pkg;

	// Stick or motor rate, valid range 0 to 250
	typedef logic [7:0] rate_t;

	// Signed angle, rate or axis command
	typedef logic signed [9:0] axis_t;

	// Decoded receiver state
	typedef struct packed {
		rate_t throttle;
		rate_t roll;
		rate_t pitch;
		rate_t yaw;
		logic  armed;
	} rc_cmd_t;

	// One IMU sample, angles and yaw rate
	typedef struct packed {
		axis_t roll_angle;
		axis_t pitch_angle;
		axis_t yaw_rate;
	} imu_sample_t;

	// Controller output toward the mixer
	typedef struct packed {
		axis_t roll_cmd;
		axis_t pitch_cmd;
		axis_t yaw_cmd;
		rate_t throttle;
		logic  armed;
	} axis_cmd_t;

	// Motor rates, X-frame numbering
	typedef struct packed {
		rate_t m1;
		rate_t m2;
		rate_t m3;
		rate_t m4;
	} motor_rates_t;

	// Hobby PWM limits in us
	localparam int RC_MIN_US = 1000;
	localparam int RC_MAX_US = 2000;

	localparam int RATE_MAX = 250;
	localparam int STICK_CENTER = 125;
	// Arm switch must read above this
	localparam int ARM_THRESHOLD = 125;

endpackage

//--- verilog/rc_receiver.sv
/* RC receiver front end */
`timescale 1ns/10ps

module rc_receiver #(
	parameter int US_DIV = 38,
	parameter int RC_TIMEOUT_US = 25000
) (
	input  logic               sys_clk,
	input  logic               resetn,
	input  logic               throttle_pwm,
	input  logic               roll_pwm,
	input  logic               pitch_pwm,
	input  logic               yaw_pwm,
	input  logic               arm_pwm,
	output flight_pkg::rc_cmd_t rc_cmd,
	output logic               us_tick
);
	import flight_pkg::*;

	localparam int NUM_CH = 5;
	// Channel slots
	localparam int CH_THR = 0;
	localparam int CH_ARM = 4;
	localparam int DIV_W = $clog2(US_DIV + 1);
	localparam int SIL_W = $clog2(RC_TIMEOUT_US + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [NUM_CH-1:0] pwm_in;
	logic [NUM_CH-1:0] sync_1;
	logic [NUM_CH-1:0] sync_2;
	logic [NUM_CH-1:0] sync_prev;
	logic [NUM_CH-1:0] rise;
	logic [NUM_CH-1:0] fall;
	logic [NUM_CH-1:0] silent;
	logic [11:0] width_us [NUM_CH];
	logic [SIL_W-1:0] quiet_us [NUM_CH];
	rate_t ch_val [NUM_CH];

	// Clamp to 1000..2000 us, then 4 us per step
	function automatic rate_t scale_width(input logic [11:0] w);
		logic [11:0] c;
		c = w;
		if (c < 12'(RC_MIN_US))
			c = 12'(RC_MIN_US);
		else if (c > 12'(RC_MAX_US))
			c = 12'(RC_MAX_US);
		c = c - 12'(RC_MIN_US);
		return rate_t'(c >> 2);
	endfunction

	assign pwm_in = {arm_pwm, yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};

	// Microsecond timebase, shared with the ESC side
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			us_tick <= 1'b0;
		end else if (div_cnt == DIV_W'(US_DIV - 1)) begin
			div_cnt <= '0;
			us_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			us_tick <= 1'b0;
		end
	end

	// Two-flop sync plus edge history
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_prev <= '0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			sync_prev <= sync_2;
		end
	end

	assign rise = sync_2 & ~sync_prev;
	assign fall = ~sync_2 & sync_prev;

	// High time in us, saturating
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (rise[i])
				width_us[i] <= '0;
			else if (sync_2[i] && us_tick && width_us[i] != 12'hfff)
				width_us[i] <= width_us[i] + 1'b1;
		end
	end

	// Capture on falling edge, silence count since last one
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			for (int i = 0; i < NUM_CH; i++) begin
				quiet_us[i] <= SIL_W'(RC_TIMEOUT_US);
				ch_val[i] <= (i == CH_THR || i == CH_ARM) ? '0 : rate_t'(STICK_CENTER);
			end
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (fall[i]) begin
					quiet_us[i] <= '0;
					ch_val[i] <= scale_width(width_us[i]);
				end else if (us_tick && !silent[i]) begin
					quiet_us[i] <= quiet_us[i] + 1'b1;
				end
			end
		end
	end

	// Counter parks at the limit until the next pulse
	always_comb begin
		for (int i = 0; i < NUM_CH; i++)
			silent[i] = (quiet_us[i] == SIL_W'(RC_TIMEOUT_US));
	end

	assign rc_cmd.throttle = ch_val[CH_THR];
	assign rc_cmd.roll = ch_val[1];
	assign rc_cmd.pitch = ch_val[2];
	assign rc_cmd.yaw = ch_val[3];
	// Failsafe, any quiet channel disarms
	assign rc_cmd.armed = (ch_val[CH_ARM] > rate_t'(ARM_THRESHOLD)) && (silent == '0);

	tick_single: assert property (@(posedge sys_clk) disable iff (!resetn)
		us_tick |=> !us_tick);

endmodule

//--- verilog/attitude_controller.sv
/* Proportional attitude controller */
`timescale 1ns/10ps

module attitude_controller #(
	parameter int GAIN_SHIFT = 1
) (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  flight_pkg::rc_cmd_t     rc_cmd,
	input  flight_pkg::imu_sample_t imu_sample,
	input  logic                    imu_valid,
	output flight_pkg::axis_cmd_t   axis_cmd,
	output logic                    cmd_valid
);
	import flight_pkg::*;

	// Stick offset minus a 10-bit measurement needs 11 bits
	typedef logic signed [10:0] err_t;

	localparam int AXIS_MAX = 511;
	localparam int AXIS_MIN = -512;

	err_t roll_err;
	err_t pitch_err;
	err_t yaw_err;
	rate_t thr_d1;
	logic armed_d1;
	logic valid_d1;

	// Centred stick target minus measured value
	function automatic err_t axis_error(input rate_t stick, input axis_t meas);
		err_t centred;
		centred = err_t'({3'b000, stick}) - err_t'(STICK_CENTER);
		return centred - err_t'(meas);
	endfunction

	// Gain shift, saturated to the axis range
	function automatic axis_t scale_cmd(input err_t e);
		err_t s;
		s = e >>> GAIN_SHIFT;
		if (s > err_t'(AXIS_MAX))
			return axis_t'(AXIS_MAX);
		if (s < err_t'(AXIS_MIN))
			return axis_t'(AXIS_MIN);
		return axis_t'(s);
	endfunction

	// Stage one, errors against the sample
	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			roll_err <= axis_error(rc_cmd.roll, imu_sample.roll_angle);
			pitch_err <= axis_error(rc_cmd.pitch, imu_sample.pitch_angle);
			yaw_err <= axis_error(rc_cmd.yaw, imu_sample.yaw_rate);
			thr_d1 <= rc_cmd.throttle;
			armed_d1 <= rc_cmd.armed;
		end
	end

	// Stage two, gain and pass-through
	always_ff @(posedge sys_clk) begin
		if (valid_d1) begin
			axis_cmd.roll_cmd <= scale_cmd(roll_err);
			axis_cmd.pitch_cmd <= scale_cmd(pitch_err);
			axis_cmd.yaw_cmd <= scale_cmd(yaw_err);
			axis_cmd.throttle <= thr_d1;
			axis_cmd.armed <= armed_d1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			valid_d1 <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			valid_d1 <= imu_valid;
			cmd_valid <= valid_d1;
		end
	end

	valid_fwd: assert property (@(posedge sys_clk) disable iff (!resetn)
		imu_valid |-> ##2 cmd_valid);
	valid_back: assert property (@(posedge sys_clk) disable iff (!resetn)
		cmd_valid |-> $past(imu_valid, 2));

endmodule

//--- verilog/motor_mixer.sv
/* X-frame motor mixer */
`timescale 1ns/10ps

module motor_mixer (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  flight_pkg::axis_cmd_t    axis_cmd,
	input  logic                     cmd_valid,
	output flight_pkg::motor_rates_t motor_rates
);
	import flight_pkg::*;

	// Throttle plus three full-scale commands fits in 12 bits
	typedef logic signed [11:0] mix_t;

	mix_t thr_s;
	mix_t roll_s;
	mix_t pitch_s;
	mix_t yaw_s;
	mix_t sum_1;
	mix_t sum_2;
	mix_t sum_3;
	mix_t sum_4;

	function automatic rate_t clamp_rate(input mix_t s);
		if (s < mix_t'(0))
			return '0;
		if (s > mix_t'(RATE_MAX))
			return rate_t'(RATE_MAX);
		return rate_t'(s);
	endfunction

	assign thr_s = mix_t'({4'b0000, axis_cmd.throttle});
	assign roll_s = mix_t'(axis_cmd.roll_cmd);
	assign pitch_s = mix_t'(axis_cmd.pitch_cmd);
	assign yaw_s = mix_t'(axis_cmd.yaw_cmd);

	// Front and rear pairs split on pitch, diagonals on yaw
	assign sum_1 = thr_s + pitch_s + roll_s - yaw_s;
	assign sum_2 = thr_s + pitch_s - roll_s + yaw_s;
	assign sum_3 = thr_s - pitch_s - roll_s - yaw_s;
	assign sum_4 = thr_s - pitch_s + roll_s + yaw_s;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_rates <= '0;
		end else if (cmd_valid) begin
			if (!axis_cmd.armed) begin
				// Disarmed, motors idle
				motor_rates <= '0;
			end else begin
				motor_rates.m1 <= clamp_rate(sum_1);
				motor_rates.m2 <= clamp_rate(sum_2);
				motor_rates.m3 <= clamp_rate(sum_3);
				motor_rates.m4 <= clamp_rate(sum_4);
			end
		end
	end

	rate_limit: assert property (@(posedge sys_clk) disable iff (!resetn)
		motor_rates.m1 <= RATE_MAX && motor_rates.m2 <= RATE_MAX &&
		motor_rates.m3 <= RATE_MAX && motor_rates.m4 <= RATE_MAX);

endmodule

//--- verilog/esc_pwm.sv
/* ESC pulse generator */
`timescale 1ns/10ps

module esc_pwm #(
	parameter int US_DIV = 38,
	parameter int ESC_FRAME_US = 2500
) (
	input  logic                     sys_clk,
	input  logic                     resetn,
	input  logic                     us_tick,
	input  flight_pkg::motor_rates_t motor_rates,
	output logic                     motor_1_pwm,
	output logic                     motor_2_pwm,
	output logic                     motor_3_pwm,
	output logic                     motor_4_pwm
);
	import flight_pkg::*;

	localparam int FC_W = $clog2(ESC_FRAME_US);

	logic [FC_W-1:0] frame_us;
	logic running;
	logic frame_start;
	motor_rates_t held;
	rate_t held_rate [4];
	logic [3:0] pwm_q;

	// High time in us for one rate
	function automatic int pulse_us(input rate_t r);
		return RC_MIN_US + 4 * int'(r);
	endfunction

	// First tick after reset opens frame zero
	assign frame_start = us_tick && (!running || frame_us == FC_W'(ESC_FRAME_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_us <= '0;
			running <= 1'b0;
		end else if (frame_start) begin
			frame_us <= '0;
			running <= 1'b1;
		end else if (us_tick) begin
			frame_us <= frame_us + 1'b1;
		end
	end

	// Rates only change at a frame boundary
	always_ff @(posedge sys_clk) begin
		if (frame_start)
			held <= motor_rates;
	end

	assign held_rate = '{held.m1, held.m2, held.m3, held.m4};

	// Registered outputs, one cycle behind the counter
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pwm_q <= '0;
		end else begin
			for (int i = 0; i < 4; i++)
				pwm_q[i] <= running && (32'(frame_us) < pulse_us(held_rate[i]));
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

	// Tick comes from the receiver divider
	tick_spacing: assert property (@(posedge sys_clk) disable iff (!resetn)
		us_tick |=> !us_tick [*US_DIV - 1]);

endmodule

//--- verilog/drone_core.sv
/* Drone flight core */
`timescale 1ns/10ps

module drone_core #(
	parameter int US_DIV = 38,
	parameter int RC_TIMEOUT_US = 25000,
	parameter int ESC_FRAME_US = 2500,
	parameter int GAIN_SHIFT = 1
) (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    throttle_pwm,
	input  logic                    roll_pwm,
	input  logic                    pitch_pwm,
	input  logic                    yaw_pwm,
	input  logic                    arm_pwm,
	input  flight_pkg::imu_sample_t imu_sample,
	input  logic                    imu_valid,
	output logic                    motor_1_pwm,
	output logic                    motor_2_pwm,
	output logic                    motor_3_pwm,
	output logic                    motor_4_pwm
);
	import flight_pkg::*;

	rc_cmd_t rc_cmd;
	axis_cmd_t axis_cmd;
	logic cmd_valid;
	motor_rates_t motor_rates;
	// One us timebase for both sides
	logic us_tick;

	rc_receiver #(
		.US_DIV(US_DIV),
		.RC_TIMEOUT_US(RC_TIMEOUT_US)
	) rc_receiver_i (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.yaw_pwm(yaw_pwm),
		.arm_pwm(arm_pwm),
		.rc_cmd(rc_cmd),
		.us_tick(us_tick)
	);

	attitude_controller #(
		.GAIN_SHIFT(GAIN_SHIFT)
	) attitude_controller_i (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.rc_cmd(rc_cmd),
		.imu_sample(imu_sample),
		.imu_valid(imu_valid),
		.axis_cmd(axis_cmd),
		.cmd_valid(cmd_valid)
	);

	motor_mixer motor_mixer_i (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.axis_cmd(axis_cmd),
		.cmd_valid(cmd_valid),
		.motor_rates(motor_rates)
	);

	esc_pwm #(
		.US_DIV(US_DIV),
		.ESC_FRAME_US(ESC_FRAME_US)
	) esc_pwm_i (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.motor_rates(motor_rates),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

endmodule

//--- sim/tb_clock.sv
/* Testbench clock and reset */
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic sys_clk,
	output logic resetn
);
	initial begin
		sys_clk = 1'b0;
		forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
	end

	// Release 1 ns after an edge, like the other inputs
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1;
		resetn = 1'b1;
	end

endmodule

//--- sim/drone_core_tb.sv
/* Drone core directed testbench */
`timescale 1ns/10ps

module drone_core_tb;
	import flight_pkg::*;

	localparam int US_DIV = 4;
	localparam int RC_TIMEOUT_US = 25000;
	localparam int ESC_FRAME_US = 2500;
	localparam int GAIN_SHIFT = 1;
	// RC frame as long as an ESC frame
	localparam int RC_FRAME_CYCLES = 2500 * US_DIV;
	localparam int ESC_WAIT_CYCLES = 3 * ESC_FRAME_US * US_DIV;
	// imu_valid to new motor rates
	localparam int MIX_LATENCY = 3;
	// Channel enable bits from throttle at bit 0 to arm at bit 4
	localparam logic [4:0] ALL_CH = 5'b11111;
	localparam logic [4:0] NO_YAW = 5'b10111;

	logic sys_clk;
	logic resetn;
	logic throttle_pwm;
	logic roll_pwm;
	logic pitch_pwm;
	logic yaw_pwm;
	logic arm_pwm;
	imu_sample_t imu_sample;
	logic imu_valid;
	logic motor_1_pwm;
	logic motor_2_pwm;
	logic motor_3_pwm;
	logic motor_4_pwm;
	// Last measured ESC high times in us
	int esc_us [4];
	int mismatches;
	int timeouts;
	int seed;

	tb_clock #(
		.PERIOD_NS(4),
		.RESET_CYCLES(2)
	) tb_clock_i (
		.sys_clk(sys_clk),
		.resetn(resetn)
	);

	drone_core #(
		.US_DIV(US_DIV),
		.RC_TIMEOUT_US(RC_TIMEOUT_US),
		.ESC_FRAME_US(ESC_FRAME_US),
		.GAIN_SHIFT(GAIN_SHIFT)
	) drone_core_i (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.yaw_pwm(yaw_pwm),
		.arm_pwm(arm_pwm),
		.imu_sample(imu_sample),
		.imu_valid(imu_valid),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

	task automatic check_value(input string name, input int actual, input int expected,
			input int tol);
		if (actual > expected + tol || actual < expected - tol) begin
			$display("mismatch at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected);
			mismatches++;
		end
	endtask

	// Proportional command with a sign-keeping shift
	function automatic int axis_command(input int stick, input int meas);
		return ((stick - STICK_CENTER) - meas) >>> GAIN_SHIFT;
	endfunction

	// X-frame sum for one motor clamped to the rate range
	function automatic int mixed_rate(input int motor, input int thr, input int r,
			input int p, input int y);
		int s;
		case (motor)
			0: s = thr + p + r - y;
			1: s = thr + p - r + y;
			2: s = thr - p - r - y;
			default: s = thr - p + r + y;
		endcase
		if (s < 0)
			s = 0;
		if (s > RATE_MAX)
			s = RATE_MAX;
		return s;
	endfunction

	// Stick value v becomes a 1000 + 4v + 2 us pulse
	// All channels rise together
	task automatic send_rc_frame(input int thr, input int roll, input int pitch,
			input int yaw, input int arm, input logic [4:0] enable);
		int high_cycles [5];
		high_cycles[0] = (RC_MIN_US + 4 * thr + 2) * US_DIV;
		high_cycles[1] = (RC_MIN_US + 4 * roll + 2) * US_DIV;
		high_cycles[2] = (RC_MIN_US + 4 * pitch + 2) * US_DIV;
		high_cycles[3] = (RC_MIN_US + 4 * yaw + 2) * US_DIV;
		high_cycles[4] = (RC_MIN_US + 4 * arm + 2) * US_DIV;
		for (int c = 0; c < RC_FRAME_CYCLES; c++) begin
			@(posedge sys_clk);
			#1;
			throttle_pwm = enable[0] && c < high_cycles[0];
			roll_pwm = enable[1] && c < high_cycles[1];
			pitch_pwm = enable[2] && c < high_cycles[2];
			yaw_pwm = enable[3] && c < high_cycles[3];
			arm_pwm = enable[4] && c < high_cycles[4];
		end
	endtask

	// One-cycle strobe followed by the fixed pipeline latency
	task automatic send_imu(input int roll_angle, input int pitch_angle, input int yaw_rate);
		@(posedge sys_clk);
		#1;
		imu_sample.roll_angle = axis_t'(roll_angle);
		imu_sample.pitch_angle = axis_t'(pitch_angle);
		imu_sample.yaw_rate = axis_t'(yaw_rate);
		imu_valid = 1'b1;
		@(posedge sys_clk);
		#1;
		imu_valid = 1'b0;
		repeat (MIX_LATENCY + 1) @(posedge sys_clk);
	endtask

	// High time of the next full ESC frame sampled on falling clock edges
	task automatic measure_escs();
		int waited;
		int high_cycles [4];
		logic [3:0] pwm;
		for (int i = 0; i < 4; i++) begin
			high_cycles[i] = 0;
			esc_us[i] = 0;
		end
		waited = 0;
		@(negedge sys_clk);
		while (motor_1_pwm && waited < ESC_WAIT_CYCLES) begin
			@(negedge sys_clk);
			waited++;
		end
		if (motor_1_pwm) begin
			$display("timeout at %0t ns: motor_1_pwm never went low", $time);
			timeouts++;
			return;
		end
		// Rising edge of motor 1 marks the frame start
		waited = 0;
		while (!motor_1_pwm && waited < ESC_WAIT_CYCLES) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!motor_1_pwm) begin
			$display("timeout at %0t ns: no ESC frame started", $time);
			timeouts++;
			return;
		end
		waited = 0;
		pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
		while (pwm != 4'b0000 && waited < ESC_WAIT_CYCLES) begin
			for (int i = 0; i < 4; i++) begin
				if (pwm[i])
					high_cycles[i]++;
			end
			@(negedge sys_clk);
			waited++;
			pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
		end
		if (pwm != 4'b0000) begin
			$display("timeout at %0t ns: an ESC output stayed high", $time);
			timeouts++;
		end
		for (int i = 0; i < 4; i++)
			esc_us[i] = high_cycles[i] / US_DIV;
	endtask

	// Measure one frame and compare with the mixing rules
	task automatic check_escs(input int thr, input int roll, input int pitch, input int yaw,
			input bit armed, input int roll_angle, input int pitch_angle,
			input int yaw_rate, input int tol);
		int r_cmd;
		int p_cmd;
		int y_cmd;
		int rate;
		measure_escs();
		r_cmd = axis_command(roll, roll_angle);
		p_cmd = axis_command(pitch, pitch_angle);
		y_cmd = axis_command(yaw, yaw_rate);
		for (int i = 0; i < 4; i++) begin
			rate = armed ? mixed_rate(i, thr, r_cmd, p_cmd, y_cmd) : 0;
			check_value($sformatf("motor_%0d_pwm", i + 1), esc_us[i],
				RC_MIN_US + 4 * rate, tol);
		end
	endtask

	task automatic apply_and_check(input int thr, input int roll, input int pitch,
			input int yaw, input int arm, input int roll_angle, input int pitch_angle,
			input int yaw_rate, input int tol);
		send_rc_frame(thr, roll, pitch, yaw, arm, ALL_CH);
		send_imu(roll_angle, pitch_angle, yaw_rate);
		check_escs(thr, roll, pitch, yaw, arm > ARM_THRESHOLD, roll_angle, pitch_angle,
			yaw_rate, tol);
	endtask

	// No RC input yet so an IMU sample that would spin motor 4 must not
	task automatic idle_after_reset();
		send_imu(-40, 30, -20);
		check_escs(0, 125, 125, 125, 1'b0, -40, 30, -20, 1);
	endtask

	task automatic throttle_sweep();
		int rnd;
		int thr;
		repeat (4) begin
			rnd = $random(seed);
			thr = (rnd & 32'h7fffffff) % 251;
			apply_and_check(thr, 125, 125, 125, 250, 0, 0, 0, 1);
		end
	endtask

	task automatic attitude_mixing();
		apply_and_check(120, 150, 100, 125, 250, 10, -6, 4, 1);
		apply_and_check(160, 90, 170, 140, 250, -20, 15, -8, 1);
	endtask

	// Saturated motors land exactly on the limits
	task automatic motor_clamping();
		apply_and_check(200, 250, 125, 125, 250, 0, 0, 0, 0);
		apply_and_check(20, 0, 125, 125, 250, 0, 0, 0, 0);
		apply_and_check(230, 125, 125, 250, 250, 0, 0, -100, 0);
	endtask

	task automatic disarm_by_switch();
		apply_and_check(200, 125, 125, 125, 125, 0, 0, 0, 1);
		apply_and_check(200, 125, 125, 125, 0, 0, 0, 0, 1);
	endtask

	// 12 frames of 2500 us leave yaw quiet past the limit
	task automatic yaw_signal_loss();
		repeat (12)
			send_rc_frame(180, 140, 110, 125, 250, NO_YAW);
		send_imu(6, -4, 2);
		check_escs(180, 140, 110, 125, 1'b0, 6, -4, 2, 1);
		// Mixing returns once yaw pulses again
		apply_and_check(180, 140, 110, 125, 250, 6, -4, 2, 1);
	endtask

	initial begin
		int waited;
		throttle_pwm = 1'b0;
		roll_pwm = 1'b0;
		pitch_pwm = 1'b0;
		yaw_pwm = 1'b0;
		arm_pwm = 1'b0;
		imu_sample = '0;
		imu_valid = 1'b0;
		mismatches = 0;
		timeouts = 0;
		seed = 80972;
		waited = 0;
		while (resetn !== 1'b1 && waited < 100) begin
			@(posedge sys_clk);
			waited++;
		end
		if (resetn !== 1'b1) begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		idle_after_reset();
		throttle_sweep();
		attitude_mixing();
		motor_clamping();
		disarm_by_switch();
		yaw_signal_loss();
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- flist.f
verilog/flight_pkg.sv
verilog/rc_receiver.sv
verilog/attitude_controller.sv
verilog/motor_mixer.sv
verilog/esc_pwm.sv
verilog/drone_core.sv
sim/tb_clock.sv
sim/drone_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the drone_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module drone_core_tb \
	-f flist.f --Mdir obj_dir -o drone_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/drone_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
